/* verilog.f */
+incdir+hw
hw/jtag_pkg.sv
hw/dbg_pkg.sv
hw/jtag_tap.sv
hw/dbg_regfile.sv
hw/raw_jtag.sv
hw/prbs_checker.sv
hw/jtag.sv
tests/jtag_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module jtag

sim:
	verilator --binary --timing -f verilog.f --top-module jtag_tb -Mdir obj_dir -o jtag_tb
	./obj_dir/jtag_tb | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/jtag_tb.sv */
`timescale 1ns/100ps

`include "jtag_macros.svh"

module jtag_tb
	import jtag_pkg::*;
	import dbg_pkg::*;
();
	typedef enum {ROW_IR, ROW_ID, ROW_WORD, ROW_ADDR, ROW_BURST, ROW_TLR} row_kind_t;

	logic clk = 1'b0;
	logic rst_n_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic rx_data_i;
	logic rx_valid_i;
	logic tdo_o;

	integer seed = 32'h68533a39;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	logic [6:0] stream_hist = 7'h7f;
	logic flip_at [0:511];

	// Stimulus table, burst rows carry the flip count in row_din
	row_kind_t row_kind [$];
	int row_len [$];
	logic [31:0] row_din [$];
	logic [31:0] row_exp [$];

	// Expected register state
	jtag_instr_t m_instr = IDCODE;
	dbg_addr_t m_addr = REG_CTRL;
	logic [1:0] m_ctrl = '0;
	dbg_word_t m_scratch = '0;
	dbg_word_t m_err = '0;
	dbg_word_t m_total = '0;

	jtag u_dut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tdo_o(tdo_o),
		.rx_data_i(rx_data_i),
		.rx_valid_i(rx_valid_i)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			fail_run("timeout: the test sequence did not finish within the cycle limit");
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_ir(input string name, input jtag_instr_t got, input jtag_instr_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_id(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic check_addr(input string name, input dbg_addr_t got, input dbg_addr_t want);
		if (got !== want)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
	endtask

	// Scan rows budget six walk cycles of 8 clk on top of the bits
	function automatic void add_row(row_kind_t kind, int len, logic [31:0] din,
			logic [31:0] want);
		row_kind.push_back(kind);
		row_len.push_back(len);
		row_din.push_back(din);
		row_exp.push_back(want);
		cycle_limit += (kind == ROW_BURST) ? len + 2 : (len + 6) * 8;
	endfunction

	function automatic dbg_word_t reg_value(dbg_addr_t a);
		case (a)
			REG_CTRL:    return {14'd0, m_ctrl};
			REG_SCRATCH: return m_scratch;
			REG_ERR:     return m_err;
			REG_TOTAL:   return m_total;
			default:     return '0;
		endcase
	endfunction

	// IR capture returns the instruction in force
	function automatic void set_instr(jtag_instr_t op);
		if (op != m_instr) begin
			add_row(ROW_IR, 4, 32'(op), 32'(m_instr));
			m_instr = op;
		end
	endfunction

	// A data scan always returns the old value of the addressed register
	function automatic void write_reg(dbg_addr_t a, dbg_word_t v);
		if (a != m_addr) begin
			set_instr(ADDR);
			add_row(ROW_ADDR, 4, 32'(a), 32'(m_addr));
			m_addr = a;
		end
		set_instr(DATA);
		add_row(ROW_WORD, 16, 32'(v), 32'(reg_value(a)));
		if (a == REG_SCRATCH)
			m_scratch = v;
		if (a == REG_CTRL) begin
			m_ctrl = v[1:0];
			// Checker held in reset while int_rstb is low
			if (!v[0]) begin
				m_err = '0;
				m_total = '0;
			end
		end
	endfunction

	function automatic void read_reg(dbg_addr_t a);
		write_reg(a, reg_value(a));
	endfunction

	function automatic void add_burst(int n, int k);
		add_row(ROW_BURST, n, 32'(k), '0);
		if (m_ctrl == 2'b11) begin
			m_total += dbg_word_t'(n);
			m_err += dbg_word_t'(k);
		end
	endfunction

	// One tck period, tdo read late in the high phase where it is stable
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		@(posedge clk);
		tck_i <= 1'b0;
		tms_i <= tms;
		tdi_i <= tdi;
		repeat (4) @(posedge clk);
		tck_i <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		tdo = tdo_o;
	endtask

	// Starts and ends in Run-Test/Idle
	task automatic scan(input logic is_ir, input int len, input logic [31:0] din,
			output logic [31:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		if (is_ir)
			tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic reset_tap();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	// PRBS7 stream, b[n] = b[n-7] ^ b[n-6], with k distinct bits inverted
	task automatic send_burst(input int n, input int k);
		int pos;
		logic nb;
		for (int i = 0; i < n; i++)
			flip_at[i] = 1'b0;
		for (int j = 0; j < k; j++) begin
			pos = $unsigned($random(seed)) % n;
			while (flip_at[pos])
				pos = (pos + 1) % n;
			flip_at[pos] = 1'b1;
		end
		for (int i = 0; i < n; i++) begin
			nb = stream_hist[6] ^ stream_hist[5];
			stream_hist = {stream_hist[5:0], nb};
			@(posedge clk);
			rx_data_i <= nb ^ flip_at[i];
			rx_valid_i <= 1'b1;
		end
		@(posedge clk);
		rx_valid_i <= 1'b0;
		rx_data_i <= 1'b0;
	endtask

	initial begin
		logic [31:0] dout;
		logic [31:0] pat;
		logic b;
		int k;
		rst_n_i <= 1'b0;
		tck_i <= 1'b0;
		tms_i <= 1'b1;
		tdi_i <= 1'b0;
		trst_n_i <= 1'b1;
		rx_data_i <= 1'b0;
		rx_valid_i <= 1'b0;

		add_row(ROW_ID, 32, $random(seed), `JTAG_IDCODE);
		set_instr(BYPASS);
		pat = $random(seed);
		add_row(ROW_WORD, 16, pat, {16'd0, pat[14:0], 1'b0});
		repeat (3) begin
			write_reg(REG_SCRATCH, dbg_word_t'($random(seed)));
			read_reg(REG_SCRATCH);
		end
		write_reg(REG_TOTAL, dbg_word_t'($random(seed)));
		read_reg(REG_TOTAL);
		// Seed the checker, then check a clean stream
		write_reg(REG_CTRL, 16'h0001);
		add_burst(7, 0);
		write_reg(REG_CTRL, 16'h0003);
		add_burst(100, 0);
		read_reg(REG_TOTAL);
		read_reg(REG_ERR);
		k = 1 + ($unsigned($random(seed)) % 8);
		add_burst(120, k);
		read_reg(REG_ERR);
		read_reg(REG_TOTAL);
		write_reg(REG_ERR, dbg_word_t'($random(seed)));
		read_reg(REG_ERR);
		write_reg(REG_CTRL, 16'h0000);
		write_reg(REG_CTRL, 16'h0003);
		read_reg(REG_TOTAL);
		read_reg(REG_ERR);
		add_row(ROW_TLR, 6, '0, '0);
		m_instr = IDCODE;
		add_row(ROW_ID, 32, $random(seed), `JTAG_IDCODE);
		set_instr(BYPASS);
		cycle_limit += 200;

		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		tck_cycle(1'b0, 1'b0, b);

		for (int r = 0; r < row_kind.size(); r++) begin
			case (row_kind[r])
				ROW_IR: begin
					scan(1'b1, row_len[r], row_din[r], dout);
					check_ir($sformatf("tdo_o row %0d", r), jtag_instr_t'(dout[3:0]),
						jtag_instr_t'(row_exp[r][3:0]));
				end
				ROW_ID: begin
					scan(1'b0, row_len[r], row_din[r], dout);
					check_id($sformatf("tdo_o row %0d", r), dout, row_exp[r]);
				end
				ROW_WORD: begin
					scan(1'b0, row_len[r], row_din[r], dout);
					check_word($sformatf("tdo_o row %0d", r), dbg_word_t'(dout[15:0]),
						dbg_word_t'(row_exp[r][15:0]));
				end
				ROW_ADDR: begin
					scan(1'b0, row_len[r], row_din[r], dout);
					check_addr($sformatf("tdo_o row %0d", r), dbg_addr_t'(dout[3:0]),
						dbg_addr_t'(row_exp[r][3:0]));
				end
				ROW_BURST: send_burst(row_len[r], int'(row_din[r]));
				default: reset_tap();
			endcase
		end

		$display("Done: no errors");
		$finish;
	end
endmodule

/* hw/jtag.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag
	import dbg_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	input wire logic rx_data_i,
	input wire logic rx_valid_i
);
	logic int_rstb;
	logic prbs_rst_n;
	prbs_mode_t prbs_mode;
	dbg_word_t err_cnt;
	dbg_word_t bit_cnt;

	// Checker held in reset until REG_CTRL releases it
	assign prbs_rst_n = rst_n_i & int_rstb;

	raw_jtag u_raw_jtag (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.err_cnt_i(err_cnt),
		.bit_cnt_i(bit_cnt),
		.tdo_o(tdo_o),
		.int_rstb_o(int_rstb),
		.prbs_mode_o(prbs_mode)
	);

	prbs_checker u_prbs_checker (
		.clk(clk),
		.rst_n_i(prbs_rst_n),
		.rx_data_i(rx_data_i),
		.rx_valid_i(rx_valid_i),
		.mode_i(prbs_mode),
		.err_cnt_o(err_cnt),
		.bit_cnt_o(bit_cnt)
	);
endmodule

`default_nettype wire

/* hw/prbs_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module prbs_checker
	import dbg_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic rx_data_i,
	input wire logic rx_valid_i,
	input wire prbs_mode_t mode_i,
	output dbg_word_t err_cnt_o,
	output dbg_word_t bit_cnt_o
);
	// Last seven bits, oldest in bit 6
	logic [6:0] pred_q;
	logic pred_bit;

	// x^7 + x^6 + 1
	assign pred_bit = pred_q[6] ^ pred_q[5];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pred_q <= '0;
			err_cnt_o <= '0;
			bit_cnt_o <= '0;
		end else if (rx_valid_i) begin
			if (mode_i == PRBS_SEED) begin
				// Lock onto the incoming stream
				pred_q <= {pred_q[5:0], rx_data_i};
			end else begin
				pred_q <= {pred_q[5:0], pred_bit};
				if (bit_cnt_o != '1)
					bit_cnt_o <= bit_cnt_o + 1'b1;
				if ((rx_data_i != pred_bit) && (err_cnt_o != '1))
					err_cnt_o <= err_cnt_o + 1'b1;
			end
		end
	end
endmodule

`default_nettype wire

/* hw/raw_jtag.sv */
`timescale 1ns/100ps
`default_nettype none

module raw_jtag
	import jtag_pkg::*;
	import dbg_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	input wire dbg_word_t err_cnt_i,
	input wire dbg_word_t bit_cnt_i,
	output logic tdo_o,
	output logic int_rstb_o,
	output prbs_mode_t prbs_mode_o
);
	logic tck_rise;
	logic tck_fall;
	logic tdi;
	logic capture_dr;
	logic shift_dr;
	logic update_dr;
	logic ir_shift;
	logic ir_tdo;
	logic dr_tdo;
	jtag_instr_t instr;

	jtag_tap u_tap (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tck_rise_o(tck_rise),
		.tck_fall_o(tck_fall),
		.tdi_o(tdi),
		.capture_dr_o(capture_dr),
		.shift_dr_o(shift_dr),
		.update_dr_o(update_dr),
		.ir_shift_o(ir_shift),
		.ir_tdo_o(ir_tdo),
		.instr_o(instr)
	);

	dbg_regfile u_regfile (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.tck_rise_i(tck_rise),
		.tdi_i(tdi),
		.capture_dr_i(capture_dr),
		.shift_dr_i(shift_dr),
		.update_dr_i(update_dr),
		.instr_i(instr),
		.err_cnt_i(err_cnt_i),
		.bit_cnt_i(bit_cnt_i),
		.dr_tdo_o(dr_tdo),
		.int_rstb_o(int_rstb_o),
		.prbs_mode_o(prbs_mode_o)
	);

	// TDO launches on the falling tck edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			tdo_o <= 1'b0;
		else if (tck_fall)
			tdo_o <= ir_shift ? ir_tdo : dr_tdo;
	end
endmodule

`default_nettype wire

/* hw/dbg_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "jtag_macros.svh"

module dbg_regfile
	import jtag_pkg::*;
	import dbg_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_rise_i,
	input wire logic tdi_i,
	input wire logic capture_dr_i,
	input wire logic shift_dr_i,
	input wire logic update_dr_i,
	input wire jtag_instr_t instr_i,
	input wire dbg_word_t err_cnt_i,
	input wire dbg_word_t bit_cnt_i,
	output logic dr_tdo_o,
	output logic int_rstb_o,
	output prbs_mode_t prbs_mode_o
);
	logic sel_id;
	logic sel_addr;
	logic sel_data;
	logic bypass_q;
	logic [31:0] id_sr_q;
	logic [`DBG_ADDR_W-1:0] addr_sr_q;
	dbg_addr_t addr_q;
	dbg_word_t data_sr_q;
	dbg_word_t rd_word;
	// {prbs_mode, int_rstb}
	logic [1:0] ctrl_q;
	dbg_word_t scratch_q;

	assign sel_id = (instr_i == IDCODE);
	assign sel_addr = (instr_i == ADDR);
	assign sel_data = (instr_i == DATA);

	always_comb begin
		case (addr_q)
			REG_CTRL:    rd_word = {{(`DBG_DATA_W-2){1'b0}}, ctrl_q};
			REG_SCRATCH: rd_word = scratch_q;
			REG_ERR:     rd_word = err_cnt_i;
			REG_TOTAL:   rd_word = bit_cnt_i;
			default:     rd_word = '0;
		endcase
	end

	// Scan chains, all LSB first
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (capture_dr_i) begin
				bypass_q <= 1'b0;
				if (sel_id)
					id_sr_q <= `JTAG_IDCODE;
				if (sel_addr)
					addr_sr_q <= addr_q;
				if (sel_data)
					data_sr_q <= rd_word;
			end else if (shift_dr_i) begin
				bypass_q <= tdi_i;
				if (sel_id)
					id_sr_q <= {tdi_i, id_sr_q[31:1]};
				if (sel_addr)
					addr_sr_q <= {tdi_i, addr_sr_q[`DBG_ADDR_W-1:1]};
				if (sel_data)
					data_sr_q <= {tdi_i, data_sr_q[`DBG_DATA_W-1:1]};
			end
		end
	end

	// Status registers take no writes
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_q <= REG_CTRL;
			ctrl_q <= '0;
			scratch_q <= '0;
		end else if (tck_rise_i && update_dr_i) begin
			if (sel_addr)
				addr_q <= dbg_addr_t'(addr_sr_q);
			if (sel_data) begin
				case (addr_q)
					REG_CTRL:    ctrl_q <= data_sr_q[1:0];
					REG_SCRATCH: scratch_q <= data_sr_q;
					default:     ;
				endcase
			end
		end
	end

	always_comb begin
		if (sel_id)
			dr_tdo_o = id_sr_q[0];
		else if (sel_addr)
			dr_tdo_o = addr_sr_q[0];
		else if (sel_data)
			dr_tdo_o = data_sr_q[0];
		else
			dr_tdo_o = bypass_q;
	end

	assign int_rstb_o = ctrl_q[0];
	assign prbs_mode_o = prbs_mode_t'(ctrl_q[1]);
endmodule

`default_nettype wire

/* hw/jtag_tap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "jtag_macros.svh"

module jtag_tap
	import jtag_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tdi_o,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o,
	output logic ir_shift_o,
	output logic ir_tdo_o,
	output jtag_instr_t instr_o
);
	// Pin order {trst_n, tdi, tms, tck}
	logic [3:0] sync1_q;
	logic [3:0] sync2_q;
	logic tck_d_q;
	logic tck_rise_q;
	logic tck_fall_q;
	logic tms_q;
	logic tdi_q;
	tap_state_t state_q;
	tap_state_t state_d;
	jtag_instr_t instr_q;
	logic [`JTAG_IR_W-1:0] ir_sr_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			tck_d_q <= 1'b0;
			tck_rise_q <= 1'b0;
			tck_fall_q <= 1'b0;
			tms_q <= 1'b1;
			tdi_q <= 1'b0;
		end else begin
			sync1_q <= {trst_n_i, tdi_i, tms_i, tck_i};
			sync2_q <= sync1_q;
			tck_d_q <= sync2_q[0];
			// tms and tdi stay aligned with the edge pulses
			tck_rise_q <= sync2_q[0] & ~tck_d_q;
			tck_fall_q <= ~sync2_q[0] & tck_d_q;
			tms_q <= sync2_q[1];
			tdi_q <= sync2_q[2];
		end
	end

	always_comb begin
		case (state_q)
			TEST_LOGIC_RESET: state_d = tms_q ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_d = tms_q ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_DR:        state_d = tms_q ? SELECT_IR : CAPTURE_DR;
			CAPTURE_DR:       state_d = tms_q ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_d = tms_q ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_d = tms_q ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_d = tms_q ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_d = tms_q ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_d = tms_q ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_IR:        state_d = tms_q ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_d = tms_q ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_d = tms_q ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_d = tms_q ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_d = tms_q ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_d = tms_q ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_d = tms_q ? SELECT_DR : RUN_TEST_IDLE;
			default:          state_d = TEST_LOGIC_RESET;
		endcase
	end

	// Synchronized trst acts as a clocked reset of the TAP
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= TEST_LOGIC_RESET;
			instr_q <= IDCODE;
		end else if (!sync2_q[3]) begin
			state_q <= TEST_LOGIC_RESET;
			instr_q <= IDCODE;
		end else if (tck_rise_q) begin
			state_q <= state_d;
			if (state_d == TEST_LOGIC_RESET)
				instr_q <= IDCODE;
			else if (state_q == UPDATE_IR)
				instr_q <= jtag_instr_t'(ir_sr_q);
		end
	end

	always_ff @(posedge clk) begin
		if (tck_rise_q) begin
			if (state_q == CAPTURE_IR)
				ir_sr_q <= instr_q;
			else if (state_q == SHIFT_IR)
				ir_sr_q <= {tdi_q, ir_sr_q[`JTAG_IR_W-1:1]};
		end
	end

	assign tck_rise_o = tck_rise_q;
	assign tck_fall_o = tck_fall_q;
	assign tdi_o = tdi_q;
	assign capture_dr_o = tck_rise_q && (state_q == CAPTURE_DR);
	assign shift_dr_o = tck_rise_q && (state_q == SHIFT_DR);
	assign update_dr_o = tck_rise_q && (state_q == UPDATE_DR);
	assign ir_shift_o = (state_q == SHIFT_IR);
	assign ir_tdo_o = ir_sr_q[0];
	assign instr_o = instr_q;
endmodule

`default_nettype wire

/* hw/dbg_pkg.sv */
package dbg_pkg;

`include "jtag_macros.svh"

	typedef logic [`DBG_DATA_W-1:0] dbg_word_t;

	// Register map, unmapped addresses read as zero
	typedef enum logic [`DBG_ADDR_W-1:0] {
		REG_CTRL    = `DBG_ADDR_W'd0,
		REG_SCRATCH = `DBG_ADDR_W'd1,
		REG_ERR     = `DBG_ADDR_W'd2,
		REG_TOTAL   = `DBG_ADDR_W'd3
	} dbg_addr_t;

	typedef enum logic {
		PRBS_SEED  = 1'b0,
		PRBS_CHECK = 1'b1
	} prbs_mode_t;

endpackage

/* hw/jtag_pkg.sv */
package jtag_pkg;

`include "jtag_macros.svh"

	// IEEE 1149.1 TAP controller states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	// Unlisted codes fall back to bypass
	typedef enum logic [`JTAG_IR_W-1:0] {
		IDCODE = `JTAG_IR_W'd1,
		ADDR   = `JTAG_IR_W'd2,
		DATA   = `JTAG_IR_W'd3,
		BYPASS = `JTAG_IR_W'd15
	} jtag_instr_t;

endpackage

/* hw/jtag_macros.svh */
`ifndef JTAG_MACROS_SVH
`define JTAG_MACROS_SVH

// Instruction register width
`define JTAG_IR_W 4

// Debug register file geometry
`define DBG_DATA_W 16
`define DBG_ADDR_W 4

// Device identification, LSB must stay 1
`define JTAG_IDCODE 32'h1A5E_0001

`endif
